/* wb_dcache_consts.svh */
`ifndef WB_DCACHE_CONSTS_SVH
`define WB_DCACHE_CONSTS_SVH

// Byte address as seen by the load/store unit
`define DCACHE_ADDR_W 32

// Data word exchanged with the load/store unit
`define DCACHE_WORD_W 32

// Line geometry, 4 words of 32 bits make a 16-byte line
`define DCACHE_LINE_WORDS 4

// Direct mapped, one line per index
`define DCACHE_LINES 16

// Index field, log2 of the line count
`define DCACHE_IDX_W 4

// Byte offset inside a line
// Word select and byte select together
`define DCACHE_OFS_W 4

`endif

/* wb_dcache_pkg.sv */
`default_nettype none

`include "wb_dcache_consts.svh"

package wb_dcache_pkg;

  // Widths with a meaning of their own
  typedef logic [`DCACHE_ADDR_W-1:0] dcache_addr_t;
  typedef logic [`DCACHE_WORD_W-1:0] dcache_word_t;
  typedef logic [`DCACHE_WORD_W/8-1:0] dcache_sel_t;
  typedef logic [`DCACHE_LINE_WORDS*`DCACHE_WORD_W-1:0] dcache_line_t;
  typedef logic [`DCACHE_IDX_W-1:0] dcache_idx_t;
  typedef logic [`DCACHE_ADDR_W-`DCACHE_IDX_W-`DCACHE_OFS_W-1:0] dcache_tag_t;

  // Load/store unit request, held until ack
  typedef struct packed {
    logic         req;
    logic         w_en;
    dcache_addr_t addr;
    dcache_word_t w_data;
    dcache_sel_t  sel_byte;
  } lsummu2dcache_s;

  // Response back to the load/store unit
  typedef struct packed {
    logic         ack;
    logic         flush_ack;
    dcache_word_t r_data;
  } dcache2lsummu_s;

  // Memory response, read line valid with ack
  typedef struct packed {
    logic         ack;
    dcache_line_t r_data;
  } mem2dcache_s;

  // Line-wide memory request, address is line aligned
  typedef struct packed {
    logic         req;
    logic         w_en;
    dcache_addr_t addr;
    dcache_line_t w_data;
  } dcache2mem_s;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    RESPOND,
    WRITEBACK,
    REFILL,
    FLUSH_CHECK,
    FLUSH_WB,
    FLUSH_DONE
  } dcache_state_e;

endpackage

`default_nettype wire

/* wb_dcache_controller.sv */
`default_nettype none

`include "wb_dcache_consts.svh"

module wb_dcache_controller (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       dmem_sel_i,
  input  logic                       dcache_flush_i,

  // Load/store unit strobes
  input  logic                       lsu_req_i,
  input  logic                       lsu_wr_i,
  output logic                       lsu_ack_o,
  output logic                       flush_ack_o,

  // Status from the datapath
  input  logic                       cache_hit_i,
  input  logic                       cache_evict_req_i,

  // Memory strobes
  input  logic                       mem_ack_i,
  output logic                       mem_req_o,
  output logic                       mem_wr_o,

  // Datapath controls
  output logic                       cache_wr_o,
  output logic                       cache_line_wr_o,
  output logic                       cache_line_clean_o,
  output logic                       cache_wrb_req_o,
  output logic                       ack_en_o,
  output wb_dcache_pkg::dcache_idx_t evict_index_o
);

  import wb_dcache_pkg::*;

  localparam dcache_idx_t LAST_LINE = dcache_idx_t'(`DCACHE_LINES - 1);

  dcache_state_e state_q;
  dcache_state_e state_d;
  dcache_idx_t   evict_index_q;
  dcache_idx_t   evict_index_d;
  logic          lsu_valid;
  logic          last_line;

  // Requests aimed at another target are ignored
  assign lsu_valid = lsu_req_i && dmem_sel_i;
  assign last_line = (evict_index_q == LAST_LINE);

  always_comb begin
    state_d            = state_q;
    evict_index_d      = evict_index_q;
    cache_wr_o         = 1'b0;
    cache_line_wr_o    = 1'b0;
    cache_line_clean_o = 1'b0;
    ack_en_o           = 1'b0;

    case (state_q)
      IDLE: begin
        if (lsu_valid) begin
          if (cache_hit_i) begin
            // Hit, store merges now and response word is captured
            ack_en_o   = 1'b1;
            cache_wr_o = lsu_wr_i;
            state_d    = RESPOND;
          end else if (cache_evict_req_i) begin
            state_d = WRITEBACK;
          end else begin
            state_d = REFILL;
          end
        end else if (dcache_flush_i) begin
          evict_index_d = '0;
          state_d       = FLUSH_CHECK;
        end
      end

      RESPOND: begin
        state_d = IDLE;
      end

      // Dirty victim goes out first, then the miss is re-evaluated
      WRITEBACK: begin
        if (mem_ack_i) begin
          cache_line_clean_o = 1'b1;
          state_d            = IDLE;
        end
      end

      REFILL: begin
        if (mem_ack_i) begin
          cache_line_wr_o = 1'b1;
          state_d         = IDLE;
        end
      end

      // Walk every index, one cycle for a clean line
      FLUSH_CHECK: begin
        if (cache_evict_req_i) begin
          state_d = FLUSH_WB;
        end else if (last_line) begin
          state_d = FLUSH_DONE;
        end else begin
          evict_index_d = evict_index_q + 1'b1;
        end
      end

      FLUSH_WB: begin
        if (mem_ack_i) begin
          cache_line_clean_o = 1'b1;
          if (last_line) begin
            state_d = FLUSH_DONE;
          end else begin
            evict_index_d = evict_index_q + 1'b1;
            state_d       = FLUSH_CHECK;
          end
        end
      end

      FLUSH_DONE: begin
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= IDLE;
      evict_index_q <= '0;
    end else begin
      state_q       <= state_d;
      evict_index_q <= evict_index_d;
    end
  end

  // Strobes decode straight from the state, held while memory is busy
  assign lsu_ack_o       = (state_q == RESPOND);
  assign flush_ack_o     = (state_q == FLUSH_DONE);
  assign mem_req_o       = (state_q == WRITEBACK) || (state_q == REFILL) ||
                           (state_q == FLUSH_WB);
  assign mem_wr_o        = (state_q == WRITEBACK) || (state_q == FLUSH_WB);
  assign cache_wrb_req_o = mem_wr_o;
  assign evict_index_o   = evict_index_q;

endmodule

`default_nettype wire

/* wb_dcache_datapath.sv */
`default_nettype none

`include "wb_dcache_consts.svh"

module wb_dcache_datapath (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Controls from the controller
  input  logic                        cache_wr_i,
  input  logic                        cache_line_wr_i,
  input  logic                        cache_line_clean_i,
  input  logic                        cache_wrb_req_i,
  input  logic                        ack_en_i,
  input  logic                        dcache_flush_i,
  input  wb_dcache_pkg::dcache_idx_t  evict_index_i,

  // Load/store unit request fields
  input  wb_dcache_pkg::dcache_addr_t lsu_addr_i,
  input  wb_dcache_pkg::dcache_word_t lsu_wdata_i,
  input  wb_dcache_pkg::dcache_sel_t  sel_byte_i,

  // Line returned by memory
  input  wb_dcache_pkg::dcache_line_t mem_rdata_i,

  // Status to the controller
  output logic                        cache_hit_o,
  output logic                        cache_evict_req_o,

  output wb_dcache_pkg::dcache_word_t lsu_rdata_o,
  output wb_dcache_pkg::dcache_line_t mem_wdata_o,
  output wb_dcache_pkg::dcache_addr_t mem_addr_o
);

  import wb_dcache_pkg::*;

  localparam int BYTES      = `DCACHE_WORD_W / 8;
  localparam int BYTE_OFS_W = $clog2(BYTES);
  localparam int WORD_SEL_W = `DCACHE_OFS_W - BYTE_OFS_W;
  localparam int TAG_W      = $bits(dcache_tag_t);

  // Storage
  dcache_tag_t              tag_array  [`DCACHE_LINES];
  dcache_line_t             data_array [`DCACHE_LINES];
  logic [`DCACHE_LINES-1:0] valid_q;
  logic [`DCACHE_LINES-1:0] dirty_q;

  dcache_tag_t              lsu_tag;
  dcache_idx_t              lsu_idx;
  logic [WORD_SEL_W-1:0]    word_ofs;
  dcache_idx_t              line_idx;
  dcache_line_t             cur_line;
  dcache_line_t             merged_line;
  dcache_word_t             rd_word;

  // Address fields of the request
  assign lsu_tag  = lsu_addr_i[`DCACHE_ADDR_W-1 -: TAG_W];
  assign lsu_idx  = lsu_addr_i[`DCACHE_OFS_W +: `DCACHE_IDX_W];
  assign word_ofs = lsu_addr_i[BYTE_OFS_W +: WORD_SEL_W];

  // The flush walk takes over the victim index
  assign line_idx = dcache_flush_i ? evict_index_i : lsu_idx;

  assign cache_hit_o       = valid_q[lsu_idx] && (tag_array[lsu_idx] == lsu_tag);
  assign cache_evict_req_o = valid_q[line_idx] && dirty_q[line_idx];

  assign cur_line = data_array[lsu_idx];
  assign rd_word  = cur_line[word_ofs*`DCACHE_WORD_W +: `DCACHE_WORD_W];

  // Byte-enable merge into the addressed word of the line
  always_comb begin
    merged_line = cur_line;
    for (int b = 0; b < BYTES; b++) begin
      if (sel_byte_i[b]) begin
        merged_line[word_ofs*`DCACHE_WORD_W + b*8 +: 8] = lsu_wdata_i[b*8 +: 8];
      end
    end
  end

  // Tag and data arrays, response word register
  always_ff @(posedge clk_i) begin
    if (cache_line_wr_i) begin
      data_array[lsu_idx] <= mem_rdata_i;
      tag_array[lsu_idx]  <= lsu_tag;
    end else if (cache_wr_i) begin
      data_array[lsu_idx] <= merged_line;
    end

    if (ack_en_i) begin
      lsu_rdata_o <= rd_word;
    end
  end

  // Valid and dirty bits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (cache_line_wr_i) begin
        valid_q[lsu_idx] <= 1'b1;
        dirty_q[lsu_idx] <= 1'b0;
      end
      if (cache_wr_i) begin
        dirty_q[lsu_idx] <= 1'b1;
      end
      // victim or walked line has been written back
      if (cache_line_clean_i) begin
        dirty_q[line_idx] <= 1'b0;
      end
    end
  end

  // Line aligned memory address, stored tag when writing back
  assign mem_addr_o  = cache_wrb_req_i ?
                       {tag_array[line_idx], line_idx, {`DCACHE_OFS_W{1'b0}}} :
                       {lsu_tag, lsu_idx, {`DCACHE_OFS_W{1'b0}}};
  assign mem_wdata_o = data_array[line_idx];

endmodule

`default_nettype wire

/* wb_dcache_top.sv */
`default_nettype none

module wb_dcache_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          dmem_sel_i,
  input  logic                          dcache_flush_i,

  // Load/store unit side
  input  wb_dcache_pkg::lsummu2dcache_s lsummu2dcache_i,
  output wb_dcache_pkg::dcache2lsummu_s dcache2lsummu_o,

  // Memory side
  input  wb_dcache_pkg::mem2dcache_s    mem2dcache_i,
  output wb_dcache_pkg::dcache2mem_s    dcache2mem_o
);

  import wb_dcache_pkg::*;

  logic         cache_hit;
  logic         cache_evict_req;
  logic         cache_wr;
  logic         cache_line_wr;
  logic         cache_line_clean;
  logic         cache_wrb_req;
  logic         ack_en;
  dcache_idx_t  evict_index;

  logic         lsu_ack;
  logic         flush_ack;
  dcache_word_t lsu_rdata;
  logic         mem_req;
  logic         mem_wr;
  dcache_addr_t mem_addr;
  dcache_line_t mem_wdata;

  wb_dcache_controller u_controller (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .dmem_sel_i         (dmem_sel_i),
    .dcache_flush_i     (dcache_flush_i),
    .lsu_req_i          (lsummu2dcache_i.req),
    .lsu_wr_i           (lsummu2dcache_i.w_en),
    .lsu_ack_o          (lsu_ack),
    .flush_ack_o        (flush_ack),
    .cache_hit_i        (cache_hit),
    .cache_evict_req_i  (cache_evict_req),
    .mem_ack_i          (mem2dcache_i.ack),
    .mem_req_o          (mem_req),
    .mem_wr_o           (mem_wr),
    .cache_wr_o         (cache_wr),
    .cache_line_wr_o    (cache_line_wr),
    .cache_line_clean_o (cache_line_clean),
    .cache_wrb_req_o    (cache_wrb_req),
    .ack_en_o           (ack_en),
    .evict_index_o      (evict_index)
  );

  wb_dcache_datapath u_datapath (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .cache_wr_i         (cache_wr),
    .cache_line_wr_i    (cache_line_wr),
    .cache_line_clean_i (cache_line_clean),
    .cache_wrb_req_i    (cache_wrb_req),
    .ack_en_i           (ack_en),
    .dcache_flush_i     (dcache_flush_i),
    .evict_index_i      (evict_index),
    .lsu_addr_i         (lsummu2dcache_i.addr),
    .lsu_wdata_i        (lsummu2dcache_i.w_data),
    .sel_byte_i         (lsummu2dcache_i.sel_byte),
    .mem_rdata_i        (mem2dcache_i.r_data),
    .cache_hit_o        (cache_hit),
    .cache_evict_req_o  (cache_evict_req),
    .lsu_rdata_o        (lsu_rdata),
    .mem_wdata_o        (mem_wdata),
    .mem_addr_o         (mem_addr)
  );

  // Pack the outgoing structs
  assign dcache2lsummu_o = '{ack: lsu_ack, flush_ack: flush_ack, r_data: lsu_rdata};
  assign dcache2mem_o    = '{req: mem_req, w_en: mem_wr, addr: mem_addr, w_data: mem_wdata};

endmodule

`default_nettype wire

/* wb_dcache_sva.sv */
`default_nettype none

module wb_dcache_sva (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input wb_dcache_pkg::dcache2lsummu_s lsu_rsp_i,
  input wb_dcache_pkg::mem2dcache_s    mem_rsp_i,
  input wb_dcache_pkg::dcache2mem_s    mem_req_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Response strobes are single-cycle pulses
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lsu_rsp_i.ack |=> !lsu_rsp_i.ack)
    else $error("ack stayed high for more than one cycle");

  flush_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lsu_rsp_i.flush_ack |=> !lsu_rsp_i.flush_ack)
    else $error("flush_ack stayed high for more than one cycle");

  // Request, direction, address and line held until memory answers
  mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i.req && !mem_rsp_i.ack |=> $stable(mem_req_i))
    else $error("memory request changed before its ack");

  ack_not_during_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(lsu_rsp_i.ack) |-> !mem_req_i.req)
    else $error("ack rose while a memory request was pending");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !lsu_rsp_i.ack && !lsu_rsp_i.flush_ack && !mem_req_i.req)
    else $error("strobe active right after reset");

endmodule

bind wb_dcache_top wb_dcache_sva u_sva (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .lsu_rsp_i (dcache2lsummu_o),
  .mem_rsp_i (mem2dcache_i),
  .mem_req_i (dcache2mem_o)
);

`default_nettype wire

/* wb_dcache_tb.sv */
`default_nettype none

`include "wb_dcache_consts.svh"

module wb_dcache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import wb_dcache_pkg::*;

  localparam int TIMEOUT   = 200;
  localparam int MEM_LINES = 1024;
  localparam int MEM_WORDS = MEM_LINES * `DCACHE_LINE_WORDS;

  logic                     clk;
  logic                     rst_n;
  logic                     dmem_sel;
  logic                     dcache_flush;
  lsummu2dcache_s           lsu_to_cache;
  dcache2lsummu_s           cache_to_lsu;
  mem2dcache_s              mem_to_cache;
  dcache2mem_s              cache_to_mem;

  // 16 KiB backing store with reference words and a tag shadow
  dcache_line_t             mem_line [MEM_LINES];
  dcache_word_t             ref_word [MEM_WORDS];
  dcache_tag_t              shadow_tag [`DCACHE_LINES];
  logic [`DCACHE_LINES-1:0] shadow_valid;
  logic [31:0]              lfsr;
  int                       mem_reqs;
  int                       mem_writes;

  wb_dcache_top UUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .dmem_sel_i      (dmem_sel),
    .dcache_flush_i  (dcache_flush),
    .lsummu2dcache_i (lsu_to_cache),
    .dcache2lsummu_o (cache_to_lsu),
    .mem2dcache_i    (mem_to_cache),
    .dcache2mem_o    (cache_to_mem)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic dcache_line_t ref_line(input dcache_addr_t a);
    dcache_line_t l;
    for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
      l[w*`DCACHE_WORD_W +: `DCACHE_WORD_W] = ref_word[{a[13:4], 2'(w)}];
    end
    return l;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input dcache_word_t got, input dcache_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_line(input string name, input dcache_line_t got, input dcache_line_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input dcache_addr_t got, input dcache_addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Memory model answers 1 to 4 cycles after it sees a request
  initial begin
    logic [1:0]  wait_bits;
    dcache2mem_s seen;
    dcache_idx_t wb_idx;

    mem_to_cache = '0;
    mem_reqs     = 0;
    mem_writes   = 0;
    lfsr         = 32'h2c56;
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
        mem_line[l][w*`DCACHE_WORD_W +: `DCACHE_WORD_W] =
          dcache_word_t'(l * 16 + w * 4) ^ 32'ha5a5_0000;
      end
    end
    forever begin
      @(posedge clk);
      if (cache_to_mem.req) begin
        seen = cache_to_mem;
        for (int b = 0; b < 2; b++) begin
          lfsr         = lfsr_next(lfsr);
          wait_bits[b] = lfsr[0];
        end
        repeat (wait_bits) @(posedge clk);
        if (seen.addr[`DCACHE_ADDR_W-1:14] != '0) begin
          stop_run("memory request outside the modelled address range");
        end
        mem_reqs++;
        if (seen.w_en) begin
          // Victim address comes from the tag held at that index
          wb_idx = seen.addr[`DCACHE_OFS_W +: `DCACHE_IDX_W];
          check_addr("mem addr", seen.addr,
                     {shadow_tag[wb_idx], wb_idx, {`DCACHE_OFS_W{1'b0}}});
          check_line("mem w_data", seen.w_data, ref_line(seen.addr));
          mem_line[seen.addr[13:4]] = seen.w_data;
          mem_writes++;
        end else begin
          check_addr("mem addr", seen.addr,
                     {lsu_to_cache.addr[`DCACHE_ADDR_W-1:`DCACHE_OFS_W],
                      {`DCACHE_OFS_W{1'b0}}});
        end
        mem_to_cache <= '{ack: 1'b1, r_data: mem_line[seen.addr[13:4]]};
        @(posedge clk);
        mem_to_cache.ack <= 1'b0;
      end
    end
  end

  task automatic access_cache(input logic wr, input dcache_addr_t addr, input dcache_word_t wdata,
                              input dcache_sel_t sel, input dcache_word_t expect_data);
    dcache_idx_t idx;
    dcache_tag_t tag;
    logic        expect_hit;
    int          reqs_before;
    int          cycles;

    idx         = addr[`DCACHE_OFS_W +: `DCACHE_IDX_W];
    tag         = addr[`DCACHE_ADDR_W-1 -: $bits(dcache_tag_t)];
    expect_hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
    reqs_before = mem_reqs;
    for (int b = 0; b < 4; b++) begin
      if (wr && sel[b]) begin
        ref_word[addr[13:2]][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    @(posedge clk);
    lsu_to_cache <= '{req: 1'b1, w_en: wr, addr: addr, w_data: wdata, sel_byte: sel};
    // Request is seen at the next edge and a hit acks one cycle later
    @(posedge clk);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_run($sformatf("no ack for the access at %h within the timeout", addr));
      end
    end while (!cache_to_lsu.ack);
    lsu_to_cache.req <= 1'b0;
    if (!wr) begin
      check_word("r_data", cache_to_lsu.r_data, expect_data);
    end
    if (expect_hit ? (cycles != 1 || mem_reqs != reqs_before) : (mem_reqs == reqs_before)) begin
      stop_run($sformatf("access at %h did not behave as a %s", addr,
                         expect_hit ? "hit" : "miss"));
    end
    shadow_valid[idx] = 1'b1;
    shadow_tag[idx]   = tag;
  endtask

  task automatic flush_cache(input int expect_wb);
    int writes_before;
    int cycles;

    writes_before = mem_writes;
    @(posedge clk);
    dcache_flush <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_run("flush_ack did not arrive within the timeout");
      end
    end while (!cache_to_lsu.flush_ack);
    dcache_flush <= 1'b0;
    if (mem_writes - writes_before != expect_wb) begin
      stop_run($sformatf("ERROR flush write-backs got 0x%0h expected 0x%0h",
                         mem_writes - writes_before, expect_wb));
    end
  endtask

  task automatic probe_unselected(input dcache_addr_t addr);
    @(posedge clk);
    dmem_sel     <= 1'b0;
    lsu_to_cache <= '{req: 1'b1, w_en: 1'b0, addr: addr, w_data: '0, sel_byte: '0};
    repeat (10) begin
      @(posedge clk);
      if (cache_to_lsu.ack || cache_to_mem.req) begin
        stop_run("cache answered a request while dmem_sel was low");
      end
    end
    lsu_to_cache.req <= 1'b0;
    dmem_sel         <= 1'b1;
  endtask

  initial begin
    int           fd;
    int           code;
    logic [7:0]   op;
    dcache_addr_t addr;
    dcache_word_t wdata;
    dcache_sel_t  sel;
    dcache_word_t expect_data;
    string        skip;

    rst_n        = 1'b0;
    dmem_sel     = 1'b1;
    dcache_flush = 1'b0;
    lsu_to_cache = '0;
    shadow_valid = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_word[i] = dcache_word_t'(i * 4) ^ 32'ha5a5_0000;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) begin
      @(posedge clk);
      if (cache_to_lsu.ack || cache_to_lsu.flush_ack || cache_to_mem.req) begin
        stop_run("strobe active after reset before any request");
      end
    end

    fd = $fopen("wb_dcache_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open wb_dcache_vectors.txt");
    end
    forever begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) begin
        break;
      end
      if (op == "#") begin
        code = $fgets(skip, fd);
        continue;
      end
      code = $fscanf(fd, " %h %h %h %h", addr, wdata, sel, expect_data);
      if (code != 4) begin
        stop_run("malformed line in the vector file");
      end
      case (op)
        "R", "W": access_cache(op == "W", addr, wdata, sel, expect_data);
        "F":      flush_cache(int'(expect_data));
        "N":      probe_unselected(addr);
        default:  stop_run("unknown operation in the vector file");
      endcase
    end
    $fclose(fd);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* wb_dcache_top.f */
+incdir+.
wb_dcache_pkg.sv
wb_dcache_controller.sv
wb_dcache_datapath.sv
wb_dcache_top.sv
wb_dcache_sva.sv
wb_dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run with Verilator, exit status follows the simulation
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module wb_dcache_tb -f wb_dcache_top.f &&
  ./obj_dir/Vwb_dcache_tb ||
  { echo "simulation did not complete cleanly"; exit 1; }

/* wb_dcache_vectors.txt */
# op addr wdata sel expect, all fields hex
# expect is read data for R, write-back count for F, unused for W and N
R 00000100 00000000 0 a5a50100
R 00000104 00000000 0 a5a50104
W 00000104 11223344 5 00000000
R 00000104 00000000 0 a5220144
W 00000238 deadbeef f 00000000
R 00001100 00000000 0 a5a51100
R 00000104 00000000 0 a5220144
W 0000110c cafef00d c 00000000
R 0000110c 00000000 0 cafe110c
N 00002340 00000000 0 00000000
F 00000000 00000000 0 00000002
F 00000000 00000000 0 00000000
R 0000110c 00000000 0 cafe110c
R 00000238 00000000 0 deadbeef
R 00002238 00000000 0 a5a52238
R 00000238 00000000 0 deadbeef
